//--- hw/panel_emu_pkg.sv
`default_nettype none

package panel_emu_pkg;

    localparam int NUM_DIGITS       = 32;
    localparam int NUM_ENC          = 3;
    localparam int NUM_SW           = 5;
    localparam int HALF_STEP_CYCLES = 30000;
    localparam int STEP_FIFO_DEPTH  = 16;

    localparam int TIMER_W    = $clog2(HALF_STEP_CYCLES + 2);
    localparam int FIFO_PTR_W = $clog2(STEP_FIFO_DEPTH);
    localparam int FIFO_CNT_W = $clog2(STEP_FIFO_DEPTH + 1);

    typedef logic [7:0]         seg_t;
    typedef logic [4:0]         digit_idx_t;
    typedef logic [NUM_SW-1:0]  sw_bits_t;
    typedef logic [NUM_ENC-1:0] enc_bits_t;
    typedef logic [31:0]        bus_addr_t;
    typedef logic [31:0]        bus_data_t;
    typedef logic [3:0]         bus_id_t;
    typedef logic [7:0]         bus_len_t;
    typedef logic [1:0]         bus_resp_t;

    typedef struct packed {
        bus_id_t   id;
        bus_addr_t addr;
        bus_len_t  len;
    } addr_req_t;

    typedef struct packed {
        bus_data_t data;
        logic      last;
    } wr_beat_t;

    typedef struct packed {
        bus_data_t data;
        bus_id_t   id;
        bus_resp_t resp;
        logic      last;
    } rd_beat_t;

    typedef struct packed {
        bus_id_t   id;
        bus_resp_t resp;
    } wr_resp_t;

    // register map
    localparam bus_addr_t ADDR_DIGIT_BASE = 32'h00;
    localparam bus_addr_t ADDR_SW_CTRL    = 32'h20;
    localparam bus_addr_t ADDR_SW_BIT4    = 32'h21; // bits 4..0 at 0x21..0x25
    localparam bus_addr_t ADDR_ENC_CTRL   = 32'h30;
    localparam bus_addr_t ADDR_ENC_STEP0  = 32'h31;

    localparam bus_resp_t RESP_OKAY   = 2'b00;
    localparam bus_data_t RD_UNMAPPED = 32'hFFFF_FFFF;

endpackage

`default_nettype wire

//--- hw/hc595_shift_reg.sv
`timescale 1ns/1ps
`default_nettype none

module hc595_shift_reg import panel_emu_pkg::*; #(
    parameter type payload_t = seg_t
) (
    input  logic     sck,
    input  logic     ser,
    input  logic     rck,
    input  logic     SLAVE_RSTN,
    output payload_t q,
    output logic     qs
);

    logic [$bits(payload_t)-1:0] chain;

    always_ff @(posedge sck or negedge SLAVE_RSTN) begin
        if (!SLAVE_RSTN) begin
            chain <= '0;
        end else begin
            chain <= {chain[$bits(payload_t)-2:0], ser}; // msb first
        end
    end

    assign qs = chain[$bits(payload_t)-1]; // cascade out

    // storage latch
    always_ff @(posedge rck or negedge SLAVE_RSTN) begin
        if (!SLAVE_RSTN) begin
            q <= '0;
        end else begin
            q <= payload_t'(chain);
        end
    end

endmodule

`default_nettype wire

//--- hw/led_capture.sv
`timescale 1ns/1ps
`default_nettype none

module led_capture import panel_emu_pkg::*; (
    input  logic       clk,
    input  logic       SLAVE_RSTN,
    input  logic       sck,
    input  logic       ser,
    input  logic       rck,
    input  digit_idx_t rd_idx,
    output seg_t       rd_seg
);

    seg_t                  lat_seg;
    digit_idx_t            lat_idx;
    logic                  seg_qs;
    logic [NUM_DIGITS-1:0] sel;
    seg_t                  digits [NUM_DIGITS];

    // segment byte shifts first, its tail feeds the digit select
    hc595_shift_reg #(.payload_t(seg_t)) u_seg_sr (
        .sck        (sck),
        .ser        (ser),
        .rck        (rck),
        .SLAVE_RSTN (SLAVE_RSTN),
        .q          (lat_seg),
        .qs         (seg_qs)
    );

    hc595_shift_reg #(.payload_t(digit_idx_t)) u_idx_sr (
        .sck        (sck),
        .ser        (seg_qs),
        .rck        (rck),
        .SLAVE_RSTN (SLAVE_RSTN),
        .q          (lat_idx),
        .qs         ()
    );

    assign sel = NUM_DIGITS'(1) << lat_idx; // 5 to 32 decode

    always_ff @(posedge clk or negedge SLAVE_RSTN) begin
        if (!SLAVE_RSTN) begin
            for (int i = 0; i < NUM_DIGITS; i++) begin
                digits[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_DIGITS; i++) begin
                if (sel[i]) begin
                    digits[i] <= ~lat_seg; // segments are active low
                end
            end
        end
    end

    assign rd_seg = digits[rd_idx];

endmodule

`default_nettype wire

//--- hw/axi_reg_slave.sv
`timescale 1ns/1ps
`default_nettype none

module axi_reg_slave import panel_emu_pkg::*; (
    input  logic       clk,
    input  logic       SLAVE_RSTN,
    // read address / data
    input  addr_req_t  ar,
    input  logic       ar_valid,
    output logic       ar_ready,
    output rd_beat_t   r,
    output logic       r_valid,
    input  logic       r_ready,
    // write address / data / response
    input  addr_req_t  aw,
    input  logic       aw_valid,
    output logic       aw_ready,
    input  wr_beat_t   w,
    input  logic       w_valid,
    output logic       w_ready,
    output wr_resp_t   b,
    output logic       b_valid,
    input  logic       b_ready,
    // digit table lookup
    output digit_idx_t rd_idx,
    input  seg_t       rd_seg,
    // panel side
    output sw_bits_t   sw_out,
    output logic       sw_oe,
    output logic       enc_oe,
    output enc_bits_t  push,
    output enc_bits_t  push_dir
);

    logic      rd_active;
    bus_id_t   rd_id;
    bus_len_t  rd_len;
    bus_len_t  rd_cnt;
    bus_addr_t rd_addr;
    bus_data_t rd_data;
    logic      ar_fire;
    logic      r_fire;

    logic      wr_active;
    bus_id_t   wr_id;
    bus_addr_t wr_addr;
    logic      aw_fire;
    logic      w_fire;

    assign ar_ready = !rd_active;
    assign ar_fire  = ar_valid && ar_ready;
    assign r_fire   = r_valid && r_ready;

    // read burst engine
    always_ff @(posedge clk or negedge SLAVE_RSTN) begin
        if (!SLAVE_RSTN) begin
            rd_active <= 1'b0;
            rd_id     <= '0;
            rd_len    <= '0;
            rd_cnt    <= '0;
            rd_addr   <= '0;
        end else if (ar_fire) begin
            rd_active <= 1'b1;
            rd_id     <= ar.id;
            rd_len    <= ar.len;
            rd_cnt    <= '0;
            rd_addr   <= ar.addr;
        end else if (r_fire) begin
            if (r.last) begin
                rd_active <= 1'b0;
            end else begin
                rd_addr <= rd_addr + 1'b1;
                rd_cnt  <= rd_cnt + 1'b1;
            end
        end
    end

    // valid one edge behind the burst flag
    always_ff @(posedge clk or negedge SLAVE_RSTN) begin
        if (!SLAVE_RSTN) begin
            r_valid <= 1'b0;
        end else if (r_fire && r.last) begin
            r_valid <= 1'b0;
        end else if (rd_active) begin
            r_valid <= 1'b1;
        end
    end

    assign rd_idx = digit_idx_t'(rd_addr - ADDR_DIGIT_BASE);

    // read map, decoded straight from the beat address
    always_comb begin
        rd_data = RD_UNMAPPED;
        if (rd_addr - ADDR_DIGIT_BASE < NUM_DIGITS) begin
            rd_data = {16'h0000, 8'(rd_idx), rd_seg};
        end
        if (rd_addr == ADDR_SW_CTRL) begin
            rd_data = 32'(sw_oe);
        end
        for (int k = 0; k < NUM_SW; k++) begin
            if (rd_addr == ADDR_SW_BIT4 + k) begin
                rd_data = 32'(sw_out[NUM_SW-1-k]);
            end
        end
        if (rd_addr == ADDR_ENC_CTRL) begin
            rd_data = 32'(enc_oe);
        end
    end

    always_comb begin
        r.data = rd_data;
        r.id   = rd_id;
        r.resp = RESP_OKAY;
        r.last = (rd_cnt == rd_len);
    end

    assign aw_ready = !wr_active;
    assign w_ready  = wr_active;
    assign aw_fire  = aw_valid && aw_ready;
    assign w_fire   = w_valid && w_ready;

    // write burst engine
    always_ff @(posedge clk or negedge SLAVE_RSTN) begin
        if (!SLAVE_RSTN) begin
            wr_active <= 1'b0;
            wr_id     <= '0;
            wr_addr   <= '0;
        end else if (aw_fire) begin
            wr_active <= 1'b1;
            wr_id     <= aw.id;
            wr_addr   <= aw.addr;
        end else if (w_fire) begin
            if (w.last) begin
                wr_active <= 1'b0;
            end else begin
                wr_addr <= wr_addr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge SLAVE_RSTN) begin
        if (!SLAVE_RSTN) begin
            b_valid <= 1'b0;
        end else if (b_valid && b_ready) begin
            b_valid <= 1'b0;
        end else if (w_fire && w.last) begin
            b_valid <= 1'b1;
        end
    end

    assign b.id   = wr_id;
    assign b.resp = RESP_OKAY;

    // register writes, only bit 0 of each beat matters
    always_ff @(posedge clk or negedge SLAVE_RSTN) begin
        if (!SLAVE_RSTN) begin
            sw_oe    <= 1'b0;
            sw_out   <= '0;
            enc_oe   <= 1'b0;
            push     <= '0;
            push_dir <= '0;
        end else begin
            push <= '0; // single cycle strobe
            if (w_fire) begin
                if (wr_addr == ADDR_SW_CTRL) begin
                    sw_oe <= w.data[0];
                end
                for (int k = 0; k < NUM_SW; k++) begin
                    if (wr_addr == ADDR_SW_BIT4 + k) begin
                        sw_out[NUM_SW-1-k] <= w.data[0];
                    end
                end
                if (wr_addr == ADDR_ENC_CTRL) begin
                    enc_oe <= w.data[0];
                end
                for (int k = 0; k < NUM_ENC; k++) begin
                    if (wr_addr == ADDR_ENC_STEP0 + k) begin
                        push[k]     <= 1'b1;
                        push_dir[k] <= w.data[0]; // 1 means A leads
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/step_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module step_fifo import panel_emu_pkg::*; (
    input  logic clk,
    input  logic SLAVE_RSTN,
    input  logic push,
    input  logic push_dir,
    input  logic pop,
    output logic empty,
    output logic pop_dir
);

    logic                  mem [STEP_FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    logic [FIFO_CNT_W-1:0] count;
    logic                  wr_en;
    logic                  rd_en;

    assign empty = (count == '0);
    assign wr_en = push && (count != FIFO_CNT_W'(STEP_FIFO_DEPTH)); // full drops
    assign rd_en = pop && !empty;

    always_ff @(posedge clk or negedge SLAVE_RSTN) begin
        if (!SLAVE_RSTN) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= push_dir;
        end
        if (rd_en) begin
            pop_dir <= mem[rd_ptr]; // valid the cycle after pop
        end
    end

endmodule

`default_nettype wire

//--- hw/encoder_step_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module encoder_step_fsm (
    input  logic clk,
    input  logic SLAVE_RSTN,
    input  logic empty,
    input  logic pop_dir,
    input  logic expired,
    output logic pop,
    output logic timer_run,
    output logic phase_a,
    output logic phase_b
);

    typedef enum logic [1:0] {
        IDLE,
        WAIT,
        READ,
        WORK
    } state_t;

    state_t state;
    logic   lead_a;

    always_ff @(posedge clk or negedge SLAVE_RSTN) begin
        if (!SLAVE_RSTN) begin
            state     <= IDLE;
            pop       <= 1'b0;
            timer_run <= 1'b0;
            lead_a    <= 1'b0;
            phase_a   <= 1'b0;
            phase_b   <= 1'b0;
        end else begin
            pop <= 1'b0;
            case (state)
                IDLE: begin
                    if (!empty) begin
                        pop   <= 1'b1;
                        state <= WAIT;
                    end
                end
                WAIT: begin
                    state <= READ; // queue output lands here
                end
                READ: begin
                    lead_a    <= pop_dir;
                    timer_run <= 1'b1;
                    if (pop_dir) begin
                        phase_a <= ~phase_a;
                    end else begin
                        phase_b <= ~phase_b;
                    end
                    state <= WORK;
                end
                WORK: begin
                    if (expired) begin
                        // trailing phase
                        if (lead_a) begin
                            phase_b <= ~phase_b;
                        end else begin
                            phase_a <= ~phase_a;
                        end
                        timer_run <= 1'b0;
                        state     <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hw/phase_timer.sv
`timescale 1ns/1ps
`default_nettype none

module phase_timer import panel_emu_pkg::*; (
    input  logic clk,
    input  logic SLAVE_RSTN,
    input  logic run,
    output logic expired
);

    logic [TIMER_W-1:0] cnt;

    always_ff @(posedge clk or negedge SLAVE_RSTN) begin
        if (!SLAVE_RSTN) begin
            cnt <= '0;
        end else if (!run) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    assign expired = run && (cnt == TIMER_W'(HALF_STEP_CYCLES)); // one cycle only

endmodule

`default_nettype wire

//--- hw/panel_emu_top.sv
`timescale 1ns/1ps
`default_nettype none

module panel_emu_top import panel_emu_pkg::*; (
    input  logic      clk,
    input  logic      SLAVE_RSTN,
    // 595 chain from the controller
    input  logic      sck,
    input  logic      ser,
    input  logic      rck,
    // burst bus
    input  addr_req_t ar,
    input  logic      ar_valid,
    output logic      ar_ready,
    input  addr_req_t aw,
    input  logic      aw_valid,
    output logic      aw_ready,
    input  wr_beat_t  w,
    input  logic      w_valid,
    output logic      w_ready,
    output rd_beat_t  r,
    output logic      r_valid,
    input  logic      r_ready,
    output wr_resp_t  b,
    output logic      b_valid,
    input  logic      b_ready,
    // panel pins, value plus enable
    output sw_bits_t  sw_out,
    output logic      sw_oe,
    output enc_bits_t enc_a,
    output enc_bits_t enc_b,
    output logic      enc_oe
);

    digit_idx_t rd_idx;
    seg_t       rd_seg;
    enc_bits_t  push;
    enc_bits_t  push_dir;
    enc_bits_t  fifo_empty;
    enc_bits_t  fifo_dir;
    enc_bits_t  fsm_pop;
    enc_bits_t  timer_run;
    enc_bits_t  timer_expired;

    led_capture u_led_capture (
        .clk        (clk),
        .SLAVE_RSTN (SLAVE_RSTN),
        .sck        (sck),
        .ser        (ser),
        .rck        (rck),
        .rd_idx     (rd_idx),
        .rd_seg     (rd_seg)
    );

    axi_reg_slave u_axi_reg_slave (
        .clk        (clk),
        .SLAVE_RSTN (SLAVE_RSTN),
        .ar         (ar),
        .ar_valid   (ar_valid),
        .ar_ready   (ar_ready),
        .r          (r),
        .r_valid    (r_valid),
        .r_ready    (r_ready),
        .aw         (aw),
        .aw_valid   (aw_valid),
        .aw_ready   (aw_ready),
        .w          (w),
        .w_valid    (w_valid),
        .w_ready    (w_ready),
        .b          (b),
        .b_valid    (b_valid),
        .b_ready    (b_ready),
        .rd_idx     (rd_idx),
        .rd_seg     (rd_seg),
        .sw_out     (sw_out),
        .sw_oe      (sw_oe),
        .enc_oe     (enc_oe),
        .push       (push),
        .push_dir   (push_dir)
    );

    // one queue, sequencer and timer per encoder channel
    for (genvar k = 0; k < NUM_ENC; k++) begin : g_enc
        step_fifo u_step_fifo (
            .clk        (clk),
            .SLAVE_RSTN (SLAVE_RSTN),
            .push       (push[k]),
            .push_dir   (push_dir[k]),
            .pop        (fsm_pop[k]),
            .empty      (fifo_empty[k]),
            .pop_dir    (fifo_dir[k])
        );

        encoder_step_fsm u_step_fsm (
            .clk        (clk),
            .SLAVE_RSTN (SLAVE_RSTN),
            .empty      (fifo_empty[k]),
            .pop_dir    (fifo_dir[k]),
            .expired    (timer_expired[k]),
            .pop        (fsm_pop[k]),
            .timer_run  (timer_run[k]),
            .phase_a    (enc_a[k]),
            .phase_b    (enc_b[k])
        );

        phase_timer u_phase_timer (
            .clk        (clk),
            .SLAVE_RSTN (SLAVE_RSTN),
            .run        (timer_run[k]),
            .expired    (timer_expired[k])
        );
    end

endmodule

`default_nettype wire

//--- sim/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
    output logic clk,
    output logic SLAVE_RSTN
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk; // 20 ns period
    end

    initial begin
        SLAVE_RSTN = 1'b0;
        repeat (16) @(posedge clk);
        SLAVE_RSTN <= 1'b1;
    end

endmodule

`default_nettype wire

//--- sim/panel_emu_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module panel_emu_asserts import panel_emu_pkg::*; (
    input logic      clk,
    input logic      SLAVE_RSTN,
    input logic      ar_ready,
    input logic      r_valid,
    input logic      aw_ready,
    input logic      w_ready,
    input logic      b_valid,
    input logic      b_ready,
    input enc_bits_t enc_a,
    input enc_bits_t enc_b
);

    int fail_cnt;

    initial fail_cnt = 0;

    rd_excl: assert property (@(posedge clk) disable iff (!SLAVE_RSTN)
        !(r_valid && ar_ready)
    ) else begin
        fail_cnt++;
        $error("r_valid high while ar_ready is high");
    end

    wr_excl: assert property (@(posedge clk) disable iff (!SLAVE_RSTN)
        !(w_ready && aw_ready)
    ) else begin
        fail_cnt++;
        $error("w_ready high while aw_ready is high");
    end

    b_hold: assert property (@(posedge clk) disable iff (!SLAVE_RSTN)
        b_valid && !b_ready |=> b_valid
    ) else begin
        fail_cnt++;
        $error("b_valid dropped before b_ready");
    end

    // quadrature, one phase per edge
    enc_phase: assert property (@(posedge clk) disable iff (!SLAVE_RSTN)
        ((enc_a ^ $past(enc_a)) & (enc_b ^ $past(enc_b))) == '0
    ) else begin
        fail_cnt++;
        $error("enc_a and enc_b of one channel toggled on the same edge");
    end

endmodule

bind panel_emu_top panel_emu_asserts u_asserts (
    .clk        (clk),
    .SLAVE_RSTN (SLAVE_RSTN),
    .ar_ready   (ar_ready),
    .r_valid    (r_valid),
    .aw_ready   (aw_ready),
    .w_ready    (w_ready),
    .b_valid    (b_valid),
    .b_ready    (b_ready),
    .enc_a      (enc_a),
    .enc_b      (enc_b)
);

`default_nettype wire

//--- sim/panel_emu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module panel_emu_tb
    import panel_emu_pkg::*;
();

    localparam int WATCHDOG_CYCLES = 8 * (HALF_STEP_CYCLES + 50);

    logic      clk;
    logic      SLAVE_RSTN;
    logic      sck;
    logic      ser;
    logic      rck;
    addr_req_t ar;
    logic      ar_valid;
    logic      ar_ready;
    addr_req_t aw;
    logic      aw_valid;
    logic      aw_ready;
    wr_beat_t  w;
    logic      w_valid;
    logic      w_ready;
    rd_beat_t  r;
    logic      r_valid;
    logic      r_ready;
    wr_resp_t  b;
    logic      b_valid;
    logic      b_ready;
    sw_bits_t  sw_out;
    logic      sw_oe;
    enc_bits_t enc_a;
    enc_bits_t enc_b;
    logic      enc_oe;

    integer    seed;
    int        cyc;
    bus_data_t exp_data [$];
    bus_data_t wr_data [$];

    tb_clk_gen u_clk_gen (
        .clk        (clk),
        .SLAVE_RSTN (SLAVE_RSTN)
    );

    panel_emu_top UUT (.*);

    always @(posedge clk) cyc <= cyc + 1;

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_data(input string name, input bus_data_t exp, input bus_data_t act);
        if (act !== exp) fail_now($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
    endtask

    task automatic check_sw(input string name, input sw_bits_t exp, input sw_bits_t act);
        if (act !== exp) fail_now($sformatf("MISMATCH %s expected %b actual %b", name, exp, act));
    endtask

    task automatic check_enc(input string name, input enc_bits_t exp, input enc_bits_t act);
        if (act !== exp) fail_now($sformatf("MISMATCH %s expected %b actual %b", name, exp, act));
    endtask

    task automatic check_resp(input string name, input bus_resp_t exp, input bus_resp_t act);
        if (act !== exp) fail_now($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
    endtask

    task automatic check_id(input string name, input bus_id_t exp, input bus_id_t act);
        if (act !== exp) fail_now($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) fail_now($sformatf("MISMATCH %s expected %b actual %b", name, exp, act));
    endtask

    task automatic check_cycles(input string name, input int exp, input int act);
        if (act != exp) fail_now($sformatf("MISMATCH %s expected %0d actual %0d", name, exp, act));
    endtask

    // r_ready toggles at random while beats are checked against exp_data
    task automatic read_burst(input string name, input bus_addr_t addr, input bus_len_t len,
                              input bus_id_t id);
        int     beat;
        integer rnd;
        beat = 0;
        @(posedge clk);
        ar       <= '{id: id, addr: addr, len: len};
        ar_valid <= 1'b1;
        @(negedge clk);
        while (!ar_ready) @(negedge clk);
        @(posedge clk);
        ar_valid <= 1'b0;
        while (beat <= int'(len)) begin
            rnd = $random(seed);
            r_ready <= rnd[0];
            @(negedge clk);
            if (r_valid && r_ready) begin
                check_data(name, exp_data[beat], r.data);
                check_resp(name, RESP_OKAY, r.resp);
                check_id(name, id, r.id);
                check_flag(name, beat == int'(len), r.last);
                beat++;
            end
            @(posedge clk);
        end
        r_ready <= 1'b0;
        exp_data.delete();
    endtask

    // beats come from wr_data and b_ready stays low for hold cycles
    task automatic write_burst(input string name, input bus_addr_t addr, input bus_id_t id,
                               input int hold);
        int n;
        n = wr_data.size();
        @(posedge clk);
        aw       <= '{id: id, addr: addr, len: bus_len_t'(n - 1)};
        aw_valid <= 1'b1;
        @(negedge clk);
        while (!aw_ready) @(negedge clk);
        @(posedge clk);
        aw_valid <= 1'b0;
        for (int i = 0; i < n; i++) begin
            w       <= '{data: wr_data[i], last: (i == n - 1)};
            w_valid <= 1'b1;
            @(negedge clk);
            while (!w_ready) @(negedge clk);
            @(posedge clk);
        end
        w_valid <= 1'b0;
        @(negedge clk);
        while (!b_valid) @(negedge clk);
        check_id(name, id, b.id);
        check_resp(name, RESP_OKAY, b.resp);
        repeat (hold) begin
            @(negedge clk);
            check_flag(name, 1'b1, b_valid);
        end
        @(posedge clk);
        b_ready <= 1'b1;
        @(posedge clk);
        b_ready <= 1'b0;
        @(negedge clk);
        check_flag(name, 1'b0, b_valid);
        wr_data.delete();
    endtask

    task automatic shift_led(input digit_idx_t idx, input seg_t seg);
        logic [12:0] bits;
        bits = {idx, seg}; // index bits first and msb first
        for (int i = 12; i >= 0; i--) begin
            @(posedge clk);
            ser <= bits[i];
            @(posedge clk);
            sck <= 1'b1;
            @(posedge clk);
            sck <= 1'b0;
        end
        @(posedge clk);
        rck <= 1'b1;
        @(posedge clk);
        rck <= 1'b0;
    endtask

    // one step on channel k with its lead and trailing edge
    task automatic watch_step(input int k, input logic lead_a);
        string     name;
        enc_bits_t pa;
        enc_bits_t pb;
        int        t0;
        name = $sformatf("encoder_steps ch%0d", k);
        pa = enc_a;
        pb = enc_b;
        do @(negedge clk); while (enc_a[k] == pa[k] && enc_b[k] == pb[k]);
        check_flag({name, " lead a"}, lead_a, enc_a[k] != pa[k]);
        check_flag({name, " lead b"}, !lead_a, enc_b[k] != pb[k]);
        t0 = cyc;
        pa = enc_a;
        pb = enc_b;
        do @(negedge clk); while (enc_a[k] == pa[k] && enc_b[k] == pb[k]);
        check_flag({name, " trail a"}, !lead_a, enc_a[k] != pa[k]);
        check_flag({name, " trail b"}, lead_a, enc_b[k] != pb[k]);
        check_cycles({name, " gap"}, HALF_STEP_CYCLES + 1, cyc - t0);
    endtask

    task automatic reset_defaults();
        @(negedge clk);
        check_flag("reset_state ar_ready", 1'b1, ar_ready);
        check_flag("reset_state aw_ready", 1'b1, aw_ready);
        check_flag("reset_state r_valid", 1'b0, r_valid);
        check_flag("reset_state b_valid", 1'b0, b_valid);
        check_flag("reset_state w_ready", 1'b0, w_ready);
        check_flag("reset_state sw_oe", 1'b0, sw_oe);
        check_flag("reset_state enc_oe", 1'b0, enc_oe);
        check_sw("reset_state sw_out", '0, sw_out);
        check_enc("reset_state enc_a", '0, enc_a);
        check_enc("reset_state enc_b", '0, enc_b);
        exp_data.push_back({16'h0000, 8'd5, 8'h00});
        read_burst("reset_state", ADDR_DIGIT_BASE + 5, 8'd0, 4'h1);
    endtask

    task automatic led_readback();
        digit_idx_t idx;
        seg_t       seg;
        idx = 5'd19;
        seg = 8'hA5;
        shift_led(idx, seg);
        exp_data.push_back({16'h0000, 3'b000, idx, ~seg});
        for (int k = 1; k < 4; k++) begin
            exp_data.push_back({16'h0000, 8'(idx + k), 8'h00}); // untouched digits
        end
        read_burst("led_capture", ADDR_DIGIT_BASE + idx, 8'd3, 4'h2);
    endtask

    task automatic switch_write_read();
        sw_bits_t pat;
        pat = 5'b10110;
        wr_data.push_back(32'hC0DE_0001); // upper bits are junk
        for (int k = 0; k < NUM_SW; k++) begin
            wr_data.push_back(32'hC0DE_0000 | 32'(pat[NUM_SW-1-k]));
        end
        write_burst("switch_regs", ADDR_SW_CTRL, 4'h9, 3);
        @(negedge clk);
        check_flag("switch_regs sw_oe", 1'b1, sw_oe);
        check_sw("switch_regs sw_out", pat, sw_out);
        exp_data.push_back(32'd1);
        for (int k = 0; k < NUM_SW; k++) begin
            exp_data.push_back(32'(pat[NUM_SW-1-k]));
        end
        read_burst("switch_regs", ADDR_SW_CTRL, 8'(NUM_SW), 4'h3);
    endtask

    task automatic unmapped_reads();
        exp_data.push_back(RD_UNMAPPED);
        read_burst("unmapped_read 0x26", 32'h26, 8'd0, 4'h4);
        exp_data.push_back(RD_UNMAPPED);
        read_burst("unmapped_read 0x50", 32'h50, 8'd0, 4'h5);
    endtask

    task automatic encoder_stepping();
        wr_data.push_back(32'd1);
        write_burst("encoder_steps enable", ADDR_ENC_CTRL, 4'h6, 0);
        exp_data.push_back(32'd1);
        read_burst("encoder_steps enc_oe", ADDR_ENC_CTRL, 8'd0, 4'h7);
        @(negedge clk);
        fork
            watch_step(0, 1'b1);
            watch_step(2, 1'b0);
            begin
                wr_data.push_back(32'd1);
                write_burst("encoder_steps push ch0", ADDR_ENC_STEP0, 4'h8, 0);
                wr_data.push_back(32'd0);
                write_burst("encoder_steps push ch2", ADDR_ENC_STEP0 + 2, 4'h8, 0);
            end
        join
        @(negedge clk);
        // channels 0 and 2 stepped once from zero, channel 1 stays at its reset level
        check_enc("encoder_steps enc_a", 3'b101, enc_a);
        check_enc("encoder_steps enc_b", 3'b101, enc_b);
        check_flag("encoder_steps enc_oe", 1'b1, enc_oe);
    endtask

    always @(posedge clk) begin
        if (UUT.u_asserts.fail_cnt != 0) fail_now("a protocol assertion fired");
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        fail_now($sformatf("timeout, tests still running after %0d cycles", WATCHDOG_CYCLES));
    end

    initial begin
        seed     = 32'hd84e9c93;
        cyc      = 0;
        sck      = 1'b0;
        ser      = 1'b0;
        rck      = 1'b0;
        ar       = '0;
        ar_valid = 1'b0;
        aw       = '0;
        aw_valid = 1'b0;
        w        = '0;
        w_valid  = 1'b0;
        r_ready  = 1'b0;
        b_ready  = 1'b0;
        wait (SLAVE_RSTN === 1'b1);
        repeat (2) @(posedge clk);
        reset_defaults();
        led_readback();
        switch_write_read();
        unmapped_reads();
        encoder_stepping();
        if (UUT.u_asserts.fail_cnt == 0) begin
            $display(">>> PASS");
            $finish;
        end else begin
            fail_now("a protocol assertion fired");
        end
    end

endmodule

`default_nettype wire

//--- project.f
hw/panel_emu_pkg.sv
hw/hc595_shift_reg.sv
hw/led_capture.sv
hw/axi_reg_slave.sv
hw/step_fifo.sv
hw/encoder_step_fsm.sv
hw/phase_timer.sv
hw/panel_emu_top.sv
sim/tb_clk_gen.sv
sim/panel_emu_asserts.sv
sim/panel_emu_tb.sv
